//--- imu_heading.f
rtl/imu_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/cmd_framer.sv
rtl/resp_parser.sv
rtl/imu_sequencer.sv
rtl/imu_heading_top.sv
test/sensor_uart_model.sv
test/imu_heading_tb.sv

//--- rtl/cmd_framer.sv
`timescale 1ns/1ps

module cmd_framer (
    input  logic                clk,
    input  logic                rst,
    input  logic                cmd_valid,
    input  imu_pkg::reg_op_t    cmd_op,
    input  imu_pkg::byte_t      cmd_reg,
    input  imu_pkg::byte_t      cmd_data,
    input  logic                tx_ready,
    output logic                cmd_ready,
    output logic                cmd_done,
    output imu_pkg::byte_t      tx_byte,
    output logic                tx_valid
);

    typedef enum logic [1:0] {
        F_IDLE,
        F_SEND,
        F_DRAIN
    } frm_state_t;

    frm_state_t       state;
    logic [2:0]       byte_idx;
    logic             last_byte;
    imu_pkg::reg_op_t op_q;
    imu_pkg::byte_t   reg_q;
    imu_pkg::byte_t   data_q;

    assign cmd_ready = (state == F_IDLE);
    assign tx_valid  = (state == F_SEND);
    assign last_byte = (byte_idx == ((op_q == imu_pkg::OP_WRITE) ? 3'd4 : 3'd3));

    always_comb begin
        case (byte_idx)
            3'd0:    tx_byte = imu_pkg::START_BYTE;
            3'd1:    tx_byte = op_q;
            3'd2:    tx_byte = reg_q;
            3'd3:    tx_byte = 8'h01;  // length, always one register
            default: tx_byte = data_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= F_IDLE;
            byte_idx <= '0;
            cmd_done <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            case (state)
                F_IDLE: begin
                    byte_idx <= '0;
                    if (cmd_valid) begin
                        state <= F_SEND;
                    end
                end
                F_SEND: begin
                    if (tx_ready) begin
                        if (last_byte) begin
                            state <= F_DRAIN;
                        end else begin
                            byte_idx <= byte_idx + 3'd1;
                        end
                    end
                end
                F_DRAIN: begin
                    if (tx_ready) begin  // last stop bit is out
                        cmd_done <= 1'b1;
                        state    <= F_IDLE;
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            op_q   <= cmd_op;
            reg_q  <= cmd_reg;
            data_q <= cmd_data;
        end
    end

endmodule

//--- rtl/imu_heading_top.sv
`timescale 1ns/1ps

module imu_heading_top #(
    parameter int CLKS_PER_BIT = 868,     // 100 MHz at 115200 baud
    parameter int BOOT_CYCLES  = 100_000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        rx,
    output logic        tx,
    output logic [15:0] heading,
    output logic        heading_valid
);

    logic                cmd_valid;
    logic                cmd_ready;
    logic                cmd_done;
    imu_pkg::reg_op_t    cmd_op;
    imu_pkg::byte_t      cmd_reg;
    imu_pkg::byte_t      cmd_data;
    imu_pkg::byte_t      tx_byte;
    logic                tx_valid;
    logic                tx_ready;
    imu_pkg::byte_t      rx_byte;
    logic                rx_valid;
    logic                resp_valid;
    imu_pkg::resp_kind_t resp_kind;
    imu_pkg::byte_t      resp_byte;

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx_i (
        .clk(clk), .rst(rst), .tx_valid(tx_valid), .tx_byte(tx_byte),
        .tx_ready(tx_ready), .tx(tx)
    );

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_rx_i (
        .clk(clk), .rst(rst), .rx(rx), .rx_byte(rx_byte), .rx_valid(rx_valid)
    );

    cmd_framer cmd_framer_i (
        .clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
        .cmd_reg(cmd_reg), .cmd_data(cmd_data), .tx_ready(tx_ready),
        .cmd_ready(cmd_ready), .cmd_done(cmd_done), .tx_byte(tx_byte),
        .tx_valid(tx_valid)
    );

    resp_parser resp_parser_i (
        .clk(clk), .rst(rst), .rx_byte(rx_byte), .rx_valid(rx_valid),
        .resp_valid(resp_valid), .resp_kind(resp_kind), .resp_byte(resp_byte)
    );

    imu_sequencer #(.BOOT_CYCLES(BOOT_CYCLES)) imu_sequencer_i (
        .clk(clk), .rst(rst), .cmd_ready(cmd_ready), .cmd_done(cmd_done),
        .resp_valid(resp_valid), .resp_kind(resp_kind), .resp_byte(resp_byte),
        .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_reg(cmd_reg),
        .cmd_data(cmd_data), .heading(heading), .heading_valid(heading_valid)
    );

endmodule

//--- rtl/imu_pkg.sv
package imu_pkg;

    typedef logic [7:0] byte_t;

    // frame header bytes
    localparam byte_t START_BYTE = 8'hAA;  // first byte of every command
    localparam byte_t ACK_HDR    = 8'hEE;  // status or error response
    localparam byte_t READ_HDR   = 8'hBB;  // successful read response
    localparam byte_t ACK_OK     = 8'h01;  // write accepted

    // sensor register map
    localparam byte_t REG_OPR_MODE    = 8'h3D;
    localparam byte_t REG_CALIB_STAT  = 8'h35;
    localparam byte_t REG_HEADING_LSB = 8'h1A;
    localparam byte_t REG_HEADING_MSB = 8'h1B;

    localparam byte_t MODE_FUSION = 8'h0C;        // absolute orientation fusion
    localparam logic [1:0] CALIB_READY = 2'd3;    // system calib field, bits 7:6

    typedef enum logic [7:0] {
        OP_WRITE = 8'h00,
        OP_READ  = 8'h01
    } reg_op_t;

    typedef enum logic [1:0] {
        RESP_ACK,   // EE frame, status byte
        RESP_DATA,  // BB frame, first data byte
        RESP_BAD    // unknown header
    } resp_kind_t;

    typedef enum logic [3:0] {
        ST_BOOT,
        ST_SET_MODE,
        ST_MODE_RESP,
        ST_CALIB,
        ST_CALIB_RESP,
        ST_HEAD_MSB,
        ST_MSB_RESP,
        ST_HEAD_LSB,
        ST_LSB_RESP
    } seq_state_t;

endpackage

//--- rtl/imu_sequencer.sv
`timescale 1ns/1ps

module imu_sequencer #(
    parameter int BOOT_CYCLES = 100_000
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cmd_ready,
    input  logic                   cmd_done,
    input  logic                   resp_valid,
    input  imu_pkg::resp_kind_t    resp_kind,
    input  imu_pkg::byte_t         resp_byte,
    output logic                   cmd_valid,
    output imu_pkg::reg_op_t       cmd_op,
    output imu_pkg::byte_t         cmd_reg,
    output imu_pkg::byte_t         cmd_data,
    output logic [15:0]            heading,
    output logic                   heading_valid
);

    localparam int BOOT_W = $clog2(BOOT_CYCLES + 1);

    imu_pkg::seq_state_t state;
    logic [BOOT_W-1:0]   boot_cnt;
    logic                sent_q;   // command accepted by framer
    logic                is_cmd_state;
    logic                is_data;
    imu_pkg::byte_t      msb_q;

    assign is_cmd_state = (state == imu_pkg::ST_SET_MODE) || (state == imu_pkg::ST_CALIB) ||
                          (state == imu_pkg::ST_HEAD_MSB) || (state == imu_pkg::ST_HEAD_LSB);
    assign cmd_valid = is_cmd_state && !sent_q;
    assign is_data   = (resp_kind == imu_pkg::RESP_DATA);

    // command fields follow the state pair
    always_comb begin
        cmd_op   = imu_pkg::OP_READ;
        cmd_reg  = imu_pkg::REG_HEADING_LSB;
        cmd_data = 8'h00;
        case (state)
            imu_pkg::ST_SET_MODE, imu_pkg::ST_MODE_RESP: begin
                cmd_op   = imu_pkg::OP_WRITE;
                cmd_reg  = imu_pkg::REG_OPR_MODE;
                cmd_data = imu_pkg::MODE_FUSION;
            end
            imu_pkg::ST_CALIB, imu_pkg::ST_CALIB_RESP: cmd_reg = imu_pkg::REG_CALIB_STAT;
            imu_pkg::ST_HEAD_MSB, imu_pkg::ST_MSB_RESP: cmd_reg = imu_pkg::REG_HEADING_MSB;
            default: cmd_reg = imu_pkg::REG_HEADING_LSB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= imu_pkg::ST_BOOT;
            boot_cnt      <= '0;
            sent_q        <= 1'b0;
            heading       <= '0;
            heading_valid <= 1'b0;
        end else begin
            heading_valid <= 1'b0;
            if (cmd_valid && cmd_ready) begin
                sent_q <= 1'b1;
            end
            if (is_cmd_state && sent_q && cmd_done) begin
                sent_q <= 1'b0;
                state  <= imu_pkg::seq_state_t'(state + 4'd1);  // to matching resp state
            end
            case (state)
                imu_pkg::ST_BOOT: begin
                    boot_cnt <= boot_cnt + BOOT_W'(1);
                    if (boot_cnt == BOOT_W'(BOOT_CYCLES - 1)) begin
                        state <= imu_pkg::ST_SET_MODE;
                    end
                end
                imu_pkg::ST_MODE_RESP: begin
                    if (resp_valid) begin
                        if (resp_kind == imu_pkg::RESP_ACK && resp_byte == imu_pkg::ACK_OK) begin
                            state <= imu_pkg::ST_CALIB;
                        end else begin
                            state <= imu_pkg::ST_SET_MODE;
                        end
                    end
                end
                imu_pkg::ST_CALIB_RESP: begin
                    if (resp_valid) begin
                        if (is_data && resp_byte[7:6] == imu_pkg::CALIB_READY) begin
                            state <= imu_pkg::ST_HEAD_MSB;
                        end else begin
                            state <= imu_pkg::ST_CALIB;  // poll again
                        end
                    end
                end
                imu_pkg::ST_MSB_RESP: begin
                    if (resp_valid) begin
                        state <= is_data ? imu_pkg::ST_HEAD_LSB : imu_pkg::ST_HEAD_MSB;
                    end
                end
                imu_pkg::ST_LSB_RESP: begin
                    if (resp_valid && is_data) begin
                        heading       <= {msb_q, resp_byte};  // same round msb
                        heading_valid <= 1'b1;
                        state         <= imu_pkg::ST_HEAD_MSB;
                    end else if (resp_valid) begin
                        state <= imu_pkg::ST_HEAD_LSB;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == imu_pkg::ST_MSB_RESP && resp_valid && is_data) begin
            msb_q <= resp_byte;
        end
    end

endmodule

//--- rtl/resp_parser.sv
`timescale 1ns/1ps

module resp_parser (
    input  logic                   clk,
    input  logic                   rst,
    input  imu_pkg::byte_t         rx_byte,
    input  logic                   rx_valid,
    output logic                   resp_valid,
    output imu_pkg::resp_kind_t    resp_kind,
    output imu_pkg::byte_t         resp_byte
);

    imu_pkg::resp_kind_t kind_q;
    logic [8:0]          cnt_q;    // bytes taken so far in this frame
    logic [8:0]          len_q;    // total frame length for BB frames
    imu_pkg::byte_t      first_q;  // first data byte
    logic                frame_end;

    assign resp_valid = rx_valid && frame_end;

    always_comb begin
        frame_end = 1'b0;
        resp_kind = kind_q;
        resp_byte = first_q;
        if (cnt_q == 9'd0) begin
            if (rx_byte != imu_pkg::ACK_HDR && rx_byte != imu_pkg::READ_HDR) begin
                frame_end = 1'b1;
                resp_kind = imu_pkg::RESP_BAD;
                resp_byte = rx_byte;
            end
        end else if (cnt_q == 9'd1) begin
            if (kind_q == imu_pkg::RESP_ACK) begin
                frame_end = 1'b1;
                resp_byte = rx_byte;  // status
            end else if (rx_byte == 8'h00) begin
                frame_end = 1'b1;     // read with no data
                resp_kind = imu_pkg::RESP_BAD;
                resp_byte = rx_byte;
            end
        end else if (cnt_q + 9'd1 == len_q) begin
            frame_end = 1'b1;
            if (cnt_q == 9'd2) begin
                resp_byte = rx_byte;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q  <= '0;
            kind_q <= imu_pkg::RESP_ACK;
        end else if (rx_valid) begin
            if (frame_end) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 9'd1;
                if (cnt_q == 9'd0) begin
                    if (rx_byte == imu_pkg::ACK_HDR) begin
                        kind_q <= imu_pkg::RESP_ACK;
                    end else begin
                        kind_q <= imu_pkg::RESP_DATA;
                    end
                end
            end
        end
    end

    // length and data capture
    always_ff @(posedge clk) begin
        if (rx_valid && cnt_q == 9'd1) begin
            len_q <= 9'(rx_byte) + 9'd2;
        end
        if (rx_valid && cnt_q == 9'd2) begin
            first_q <= rx_byte;
        end
    end

endmodule

//--- rtl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              rx,
    output imu_pkg::byte_t    rx_byte,
    output logic              rx_valid
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t        state;
    logic             rx_meta;
    logic             rx_sync;
    logic             rx_prev;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    imu_pkg::byte_t   shreg;

    assign rx_byte = shreg;

    // two-flop synchronizer plus edge history
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            clk_cnt  <= clk_cnt + CNT_W'(1);
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= RX_START;  // falling edge
                    end
                end
                RX_START: begin
                    if (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;  // glitch check
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                        rx_valid <= rx_sync;  // framing error drops the byte
                        state    <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // data arrives lsb first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            shreg <= {rx_sync, shreg[7:1]};
        end
    end

endmodule

//--- rtl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              tx_valid,
    input  imu_pkg::byte_t    tx_byte,
    output logic              tx_ready,
    output logic              tx
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

    logic             busy;
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_idx;   // 0 start, 1..8 data, 9 stop
    logic [8:0]       frame_q;

    assign tx_ready = !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;  // line idles high
        end else if (!busy) begin
            if (tx_valid) begin
                busy    <= 1'b1;
                clk_cnt <= '0;
                bit_idx <= '0;
                tx      <= 1'b0;  // start bit goes out right away
            end
        end else if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            if (bit_idx == 4'd9) begin
                busy <= 1'b0;  // stop bit done
            end else begin
                bit_idx <= bit_idx + 4'd1;
                tx      <= frame_q[bit_idx];
            end
        end else begin
            clk_cnt <= clk_cnt + CNT_W'(1);
        end
    end

    // stop above data, lsb first
    always_ff @(posedge clk) begin
        if (!busy && tx_valid) begin
            frame_q <= {1'b1, tx_byte};
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

top=imu_heading_tb
log=sim.log

verilator --binary --timing --assert --top-module "$top" -f imu_heading.f -o "sim_$top"
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/"sim_$top" | tee "$log"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "simulation exited with an error"
    exit 1
fi

# pass only if the testbench printed its pass line
if grep -qx "Everything OK" "$log"; then
    exit 0
fi
echo "pass line not found in $log"
exit 1

//--- test/imu_heading_tb.sv
`timescale 1ns/1ps

module imu_heading_tb;

    localparam int CLKS_PER_BIT = 16;
    localparam int BOOT_CYCLES  = 200;
    localparam int ROUNDS       = 8;
    localparam int CMD_FRAMES   = 2 * 5 + 2 * 4 + 2 * ROUNDS * 4 + 4 * 4 + 4;
    localparam int REPLY_FRAMES = 2 * 2 + 2 * 3 + 2 * ROUNDS * 3 + 2 * 2 + 2 * 3;
    localparam int WATCHDOG_NS  =
        ((CMD_FRAMES + REPLY_FRAMES) * 10 * CLKS_PER_BIT + BOOT_CYCLES) * 10 * 2;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        rx;
    logic        tx;
    logic [15:0] heading;
    logic        heading_valid;

    int          errors;
    int          tests_run;
    int          tests_failed;
    int          next_cmd;
    int          pulses;
    logic        valid_q;
    logic [15:0] exp_heading;
    logic [15:0] round_val [ROUNDS + 1];

    imu_heading_top #(.CLKS_PER_BIT(CLKS_PER_BIT), .BOOT_CYCLES(BOOT_CYCLES)) dut_i (
        .clk(clk), .rst(rst), .rx(rx), .tx(tx), .heading(heading),
        .heading_valid(heading_valid)
    );

    sensor_uart_model #(.CLKS_PER_BIT(CLKS_PER_BIT)) model_i (
        .clk(clk), .line_in(tx), .line_out(rx)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // every heading pulse is checked against the round in progress
    always @(negedge clk) begin
        if (rst) begin
            valid_q = 1'b0;
        end else begin
            if (heading_valid) begin
                pulses++;
                assert (heading == exp_heading) else begin
                    $display("[FAIL] heading got %h expected %h", heading, exp_heading);
                    errors++;
                end
                assert (!valid_q) else begin
                    $display("heading_valid stayed high for more than one cycle");
                    errors++;
                end
            end
            valid_q = heading_valid;
        end
    end

    task automatic expect_cmd(input logic [39:0] exp);
        logic [39:0] got;
        while (model_i.cmd_count() <= next_cmd) begin
            @(negedge clk);
        end
        got = model_i.cmd_at(next_cmd);
        assert (got == exp) else begin
            $display("[FAIL] tx command %0d got %h expected %h", next_cmd, got, exp);
            errors++;
        end
        next_cmd++;
    endtask

    task automatic wait_pulses(input int n);
        while (pulses < n) begin
            @(negedge clk);
        end
        assert (pulses == n) else begin
            $display("[FAIL] heading_valid count got %h expected %h", pulses, n);
            errors++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int err_start);
        tests_run++;
        if (errors != err_start) begin
            tests_failed++;
            $display("test %0d %s: failed", num, name);
        end else begin
            $display("test %0d %s: passed", num, name);
        end
    endtask

    initial begin
        logic [31:0] seed;
        int          err_start;
        int          boot_wait;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        next_cmd     = 0;
        pulses       = 0;
        exp_heading  = 16'h0000;
        seed         = 32'd28564;
        for (int r = 0; r <= ROUNDS; r++) begin
            seed         = xorshift32(seed);
            round_val[r] = seed[15:0];
        end
        model_i.add_reply(1'b0, 8'h07);  // mode write refused once
        model_i.add_reply(1'b0, 8'h01);
        model_i.add_reply(1'b1, 8'h3F);  // system calib not ready
        model_i.add_reply(1'b1, 8'hFF);
        for (int r = 0; r < ROUNDS; r++) begin
            model_i.add_reply(1'b1, round_val[r][15:8]);
            model_i.add_reply(1'b1, round_val[r][7:0]);
        end
        model_i.add_reply(1'b0, 8'h07);  // both heading reads fail once
        model_i.add_reply(1'b1, round_val[ROUNDS][15:8]);
        model_i.add_reply(1'b0, 8'h07);
        model_i.add_reply(1'b1, round_val[ROUNDS][7:0]);

        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        err_start = errors;
        @(negedge clk);
        assert (tx === 1'b1) else begin
            $display("[FAIL] tx got %h expected 1", tx);
            errors++;
        end
        assert (heading === 16'h0000) else begin
            $display("[FAIL] heading got %h expected 0000", heading);
            errors++;
        end
        assert (heading_valid === 1'b0) else begin
            $display("[FAIL] heading_valid got %h expected 0", heading_valid);
            errors++;
        end
        boot_wait = 0;
        while (tx !== 1'b0) begin
            @(negedge clk);
            boot_wait++;
        end
        assert (boot_wait >= BOOT_CYCLES) else begin
            $display("[FAIL] tx start cycle got %h expected at least %h", boot_wait,
                     BOOT_CYCLES);
            errors++;
        end
        report_test(1, "reset and boot", err_start);

        err_start = errors;
        expect_cmd(40'hAA_00_3D_01_0C);
        expect_cmd(40'hAA_00_3D_01_0C);  // retry after status 07
        report_test(2, "mode set with retry", err_start);

        err_start = errors;
        expect_cmd(40'hAA_01_35_01_00);
        expect_cmd(40'hAA_01_35_01_00);  // bits 7:6 of 3F are 0
        expect_cmd(40'hAA_01_1B_01_00);
        report_test(3, "calibration poll", err_start);

        err_start = errors;
        for (int r = 0; r < ROUNDS; r++) begin
            exp_heading = round_val[r];
            if (r > 0) begin
                expect_cmd(40'hAA_01_1B_01_00);
            end
            expect_cmd(40'hAA_01_1A_01_00);
            wait_pulses(r + 1);
        end
        report_test(4, "heading rounds", err_start);

        err_start   = errors;
        exp_heading = round_val[ROUNDS];
        expect_cmd(40'hAA_01_1B_01_00);
        expect_cmd(40'hAA_01_1B_01_00);
        expect_cmd(40'hAA_01_1A_01_00);
        expect_cmd(40'hAA_01_1A_01_00);
        assert (pulses == ROUNDS) else begin
            $display("[FAIL] heading_valid count got %h expected %h", pulses, ROUNDS);
            errors++;
        end
        wait_pulses(ROUNDS + 1);
        expect_cmd(40'hAA_01_1B_01_00);  // loop carries on
        assert (model_i.bad_frames == 0) else begin
            $display("the sensor model saw %0d malformed frames on tx", model_i.bad_frames);
            errors++;
        end
        report_test(5, "read error", err_start);

        $display("tests run %0d, tests failed %0d, failed checks %0d", tests_run,
                 tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the DUT stopped making progress",
                 WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

endmodule

//--- test/sensor_uart_model.sv
`timescale 1ns/1ps

module sensor_uart_model #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic clk,
    input  logic line_in,   // from DUT tx
    output logic line_out   // to DUT rx
);

    logic [39:0] cmd_log[$];  // one entry per command, read frames padded with 00
    logic [8:0]  reply_q[$];  // bit 8 set gives BB 01 data, clear gives EE status
    int          bad_frames;

    function automatic int cmd_count();
        return cmd_log.size();
    endfunction

    function automatic logic [39:0] cmd_at(input int idx);
        return cmd_log[idx];
    endfunction

    task automatic add_reply(input logic is_data, input logic [7:0] value);
        reply_q.push_back({is_data, value});
    endtask

    // sampled on the falling clock edge, away from DUT updates
    task automatic recv_byte(output logic [7:0] b);
        @(negedge clk);
        while (line_in !== 1'b0) begin
            @(negedge clk);
        end
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        if (line_in !== 1'b0) begin
            bad_frames++;  // start bit gone at mid-bit
        end
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            b[i] = line_in;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        if (line_in !== 1'b1) begin
            bad_frames++;  // stop bit low
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1 line_out = frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    initial begin
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        logic [7:0] b4;
        logic [8:0] reply;
        line_out   = 1'b1;
        bad_frames = 0;
        forever begin
            recv_byte(b0);
            if (b0 != 8'hAA) begin
                bad_frames++;  // out of step, hunt for the next start byte
            end else begin
                recv_byte(b1);
                recv_byte(b2);
                recv_byte(b3);
                b4 = 8'h00;
                if (b1 == 8'h00) begin
                    recv_byte(b4);  // writes carry a data byte
                end
                cmd_log.push_back({b0, b1, b2, b3, b4});
                if (reply_q.size() > 0) begin
                    reply = reply_q.pop_front();
                    if (reply[8]) begin
                        send_byte(8'hBB);
                        send_byte(8'h01);
                    end else begin
                        send_byte(8'hEE);
                    end
                    send_byte(reply[7:0]);
                end
            end
        end
    end

endmodule
